// File: ramtest_macros.svh
//--------------------
// RAM test sizes
// Word, block and FIFO sizes, memory depth and the
// timing of the on-chip memory model
//--------------------
`ifndef RAMTEST_MACROS_SVH
`define RAMTEST_MACROS_SVH

// Host and memory word widths
`define NARROW_W 32
`define WIDE_W 256
`define PACK 8

// Host block throttle
`define BLOCK_NARROW 16
`define HEADROOM 4

// FIFO capacities in wide words
`define IN_DEPTH_WIDE 16
`define OUT_DEPTH_WIDE 16
`define NARROW_CNT_W 8
`define WIDE_CNT_W 5

// Memory model
`define MEM_WORDS 32
`define ADDR_W 30
`define CALIB_CYCLES 64
`define RD_LATENCY 3
`define RDY_PERIOD 4

`endif

// File: ramtest_pkg.sv
//--------------------
// RAM test types
// Word, count and command types, engine states
//--------------------
`include "ramtest_macros.svh"

package ramtest_pkg;

	typedef logic [`NARROW_W-1:0] narrow_t;
	typedef logic [`WIDE_W-1:0] wide_t;

	// Address in narrow-word units, one wide word per 8
	typedef logic [`ADDR_W-1:0] app_addr_t;

	typedef logic [`NARROW_CNT_W-1:0] narrow_count_t;
	typedef logic [`WIDE_CNT_W-1:0] wide_count_t;

	typedef logic [2:0] app_cmd_t;
	localparam app_cmd_t CMD_WRITE = 3'd0;
	localparam app_cmd_t CMD_READ = 3'd1;

	typedef enum logic [1:0] {
		ST_WAIT_CALIB,
		ST_IDLE,
		ST_WRITE,
		ST_READ
	} engine_state_t;

endpackage

// File: pipe_in_fifo.sv
//--------------------
// Pipe-in FIFO
// Packs 32-bit host words into 256-bit memory words
// and flags room for one more host block
//--------------------
`include "ramtest_macros.svh"

module pipe_in_fifo (
	input  logic                      okClk,
	input  logic                      rst,
	input  logic                      wr_en,
	input  ramtest_pkg::narrow_t      din,
	input  logic                      rd_en,
	output ramtest_pkg::wide_t        dout,
	output ramtest_pkg::wide_count_t  count,
	output logic                      empty,
	output logic                      block_space
);

	localparam int PTR_W = $clog2(`IN_DEPTH_WIDE);
	localparam int LANE_W = $clog2(`PACK);
	localparam int CAP_NARROW = `IN_DEPTH_WIDE * `PACK;
	localparam int SPACE_LIMIT = CAP_NARROW - `BLOCK_NARROW - `HEADROOM;

	ramtest_pkg::wide_t mem [0:`IN_DEPTH_WIDE-1];
	ramtest_pkg::wide_t asm_word;
	ramtest_pkg::wide_t commit_word;
	ramtest_pkg::wide_count_t wcount;
	ramtest_pkg::narrow_count_t narrow_cnt;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [LANE_W-1:0] asm_idx;
	logic wr_ok;
	logic rd_ok;
	logic commit;

	assign empty = (wcount == '0);
	assign count = wcount;
	assign dout = mem[rd_ptr];

	// Partial word counts toward the fill level
	assign wr_ok = wr_en && (narrow_cnt != CAP_NARROW);
	assign rd_ok = rd_en && !empty;
	assign commit = wr_ok && (asm_idx == `PACK - 1);

	// Last word goes straight into the top lane
	always_comb begin
		commit_word = asm_word;
		commit_word[`WIDE_W-`NARROW_W +: `NARROW_W] = din;
	end

	always_ff @(posedge okClk) begin
		if (wr_ok)
			asm_word[asm_idx*`NARROW_W +: `NARROW_W] <= din;
		if (commit)
			mem[wr_ptr] <= commit_word;
	end

	always_ff @(posedge okClk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			asm_idx <= '0;
			wcount <= '0;
			narrow_cnt <= '0;
			block_space <= 1'b1;
		end else begin
			if (wr_ok)
				asm_idx <= asm_idx + 1'b1;
			if (commit)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
			wcount <= wcount + commit - rd_ok;
			case ({wr_ok, rd_ok})
				2'b10: narrow_cnt <= narrow_cnt + 1'b1;
				2'b01: narrow_cnt <= narrow_cnt - ramtest_pkg::narrow_count_t'(`PACK);
				2'b11: narrow_cnt <= narrow_cnt - ramtest_pkg::narrow_count_t'(`PACK - 1);
				default: narrow_cnt <= narrow_cnt;
			endcase
			// Room for a whole block plus headroom
			block_space <= (narrow_cnt <= SPACE_LIMIT);
		end
	end

endmodule

// File: pipe_out_fifo.sv
//--------------------
// Pipe-out FIFO
// Holds 256-bit memory words and hands them to the host
// 32 bits at a time, flags a full block ready
//--------------------
`include "ramtest_macros.svh"

module pipe_out_fifo (
	input  logic                      okClk,
	input  logic                      rst,
	input  logic                      wr_en,
	input  ramtest_pkg::wide_t        din,
	input  logic                      rd_en,
	output ramtest_pkg::narrow_t      dout,
	output ramtest_pkg::wide_count_t  count,
	output logic                      block_avail
);

	localparam int PTR_W = $clog2(`OUT_DEPTH_WIDE);
	localparam int LANE_W = $clog2(`PACK);

	ramtest_pkg::wide_t mem [0:`OUT_DEPTH_WIDE-1];
	ramtest_pkg::wide_t head;
	ramtest_pkg::wide_count_t wcount;
	ramtest_pkg::narrow_count_t narrow_cnt;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [LANE_W-1:0] sub_idx;
	logic wr_ok;
	logic rd_ok;
	logic pop;

	assign count = wcount;

	// Current narrow lane of the head word
	assign head = mem[rd_ptr];
	assign dout = head[sub_idx*`NARROW_W +: `NARROW_W];

	assign wr_ok = wr_en && (wcount != `OUT_DEPTH_WIDE);
	assign rd_ok = rd_en && (wcount != '0);
	assign pop = rd_ok && (sub_idx == `PACK - 1);

	always_ff @(posedge okClk) begin
		if (wr_ok)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge okClk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			sub_idx <= '0;
			wcount <= '0;
			narrow_cnt <= '0;
			block_avail <= 1'b0;
		end else begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_ok)
				sub_idx <= sub_idx + 1'b1;
			// Head word leaves after its eighth lane
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			wcount <= wcount + wr_ok - pop;
			case ({wr_ok, rd_ok})
				2'b10: narrow_cnt <= narrow_cnt + ramtest_pkg::narrow_count_t'(`PACK);
				2'b01: narrow_cnt <= narrow_cnt - 1'b1;
				2'b11: narrow_cnt <= narrow_cnt + ramtest_pkg::narrow_count_t'(`PACK - 1);
				default: narrow_cnt <= narrow_cnt;
			endcase
			block_avail <= (narrow_cnt >= `BLOCK_NARROW);
		end
	end

endmodule

// File: ddr3_test.sv
//--------------------
// Memory traffic engine
// Writes packed words from the pipe-in FIFO to sequential
// addresses and reads them back into the pipe-out FIFO
//--------------------
`include "ramtest_macros.svh"

module ddr3_test (
	input  logic                      okClk,
	input  logic                      rst,
	input  logic                      reads_en,
	input  logic                      writes_en,
	input  logic                      calib_done,

	output logic                      ib_re,
	input  ramtest_pkg::wide_t        ib_data,
	input  ramtest_pkg::wide_count_t  ib_count,

	output logic                      ob_we,
	output ramtest_pkg::wide_t        ob_data,
	input  ramtest_pkg::wide_count_t  ob_count,

	input  logic                      app_rdy,
	output logic                      app_en,
	output ramtest_pkg::app_cmd_t     app_cmd,
	output ramtest_pkg::app_addr_t    app_addr,
	input  logic                      app_wdf_rdy,
	output logic                      app_wdf_wren,
	output ramtest_pkg::wide_t        app_wdf_data,
	input  ramtest_pkg::wide_t        app_rd_data,
	input  logic                      app_rd_data_valid
);

	localparam ramtest_pkg::app_addr_t LAST_ADDR = (`MEM_WORDS - 1) * `PACK;
	localparam ramtest_pkg::app_addr_t ADDR_STEP = `PACK;

	ramtest_pkg::engine_state_t state;
	ramtest_pkg::app_addr_t wr_addr;
	ramtest_pkg::app_addr_t rd_addr;
	ramtest_pkg::wide_count_t rd_outstanding;
	ramtest_pkg::wide_count_t ob_free;
	// Wide words written and not yet read back
	logic [15:0] unread;
	logic space_ok;
	logic wr_acc;
	logic rd_acc;
	logic rd_done;

	// Output FIFO must hold every read already in flight
	assign ob_free = ramtest_pkg::wide_count_t'(`OUT_DEPTH_WIDE) - ob_count;
	assign space_ok = (ob_free > rd_outstanding);

	// App command side
	assign app_en = (state == ramtest_pkg::ST_WRITE)
		|| ((state == ramtest_pkg::ST_READ) && space_ok);
	assign app_cmd = (state == ramtest_pkg::ST_READ) ? ramtest_pkg::CMD_READ
		: ramtest_pkg::CMD_WRITE;
	assign app_addr = (state == ramtest_pkg::ST_READ) ? rd_addr : wr_addr;
	assign app_wdf_wren = (state == ramtest_pkg::ST_WRITE);
	assign app_wdf_data = ib_data;

	assign wr_acc = (state == ramtest_pkg::ST_WRITE) && app_rdy && app_wdf_rdy;
	assign rd_acc = (state == ramtest_pkg::ST_READ) && space_ok && app_rdy;

	// Pop the input word together with the accepted write
	assign ib_re = wr_acc;

	// Reads retire when the returned word reaches the FIFO
	assign rd_done = ob_we;

	//--------------------
	// State machine
	//--------------------
	always_ff @(posedge okClk) begin
		if (rst) begin
			state <= ramtest_pkg::ST_WAIT_CALIB;
		end else begin
			case (state)
				ramtest_pkg::ST_WAIT_CALIB: begin
					if (calib_done)
						state <= ramtest_pkg::ST_IDLE;
				end
				ramtest_pkg::ST_IDLE: begin
					// Writes take priority over reads
					if (writes_en && (ib_count != '0))
						state <= ramtest_pkg::ST_WRITE;
					else if (reads_en && (unread != '0) && space_ok)
						state <= ramtest_pkg::ST_READ;
				end
				ramtest_pkg::ST_WRITE: begin
					if (wr_acc)
						state <= ramtest_pkg::ST_IDLE;
				end
				ramtest_pkg::ST_READ: begin
					if (rd_acc)
						state <= ramtest_pkg::ST_IDLE;
				end
				default: state <= ramtest_pkg::ST_WAIT_CALIB;
			endcase
		end
	end

	//--------------------
	// Addresses and counters
	//--------------------
	always_ff @(posedge okClk) begin
		if (rst) begin
			wr_addr <= '0;
			rd_addr <= '0;
			rd_outstanding <= '0;
			unread <= '0;
			ob_we <= 1'b0;
		end else begin
			if (wr_acc)
				wr_addr <= (wr_addr == LAST_ADDR) ? '0 : wr_addr + ADDR_STEP;
			if (rd_acc)
				rd_addr <= (rd_addr == LAST_ADDR) ? '0 : rd_addr + ADDR_STEP;
			rd_outstanding <= rd_outstanding + rd_acc - rd_done;
			unread <= unread + wr_acc - rd_acc;
			ob_we <= app_rd_data_valid;
		end
	end

	always_ff @(posedge okClk) begin
		if (app_rd_data_valid)
			ob_data <= app_rd_data;
	end

endmodule

// File: app_mem.sv
//--------------------
// On-chip memory model
// App-style command port with calibration delay,
// periodic not-ready cycles and fixed read latency
//--------------------
`include "ramtest_macros.svh"

module app_mem (
	input  logic                    okClk,
	input  logic                    rst,
	input  logic                    app_en,
	input  ramtest_pkg::app_cmd_t   app_cmd,
	input  ramtest_pkg::app_addr_t  app_addr,
	input  logic                    app_wdf_wren,
	input  ramtest_pkg::wide_t      app_wdf_data,
	output logic                    app_rdy,
	output logic                    app_wdf_rdy,
	output ramtest_pkg::wide_t      app_rd_data,
	output logic                    app_rd_data_valid,
	output logic                    calib_done
);

	localparam int MEM_AW = $clog2(`MEM_WORDS);
	localparam int LANE_W = $clog2(`PACK);
	localparam int CAL_W = $clog2(`CALIB_CYCLES + 1);
	localparam int PH_W = $clog2(`RDY_PERIOD);

	ramtest_pkg::wide_t mem [0:`MEM_WORDS-1];
	ramtest_pkg::wide_t rd_pipe [0:`RD_LATENCY-1];
	logic [`RD_LATENCY-1:0] vld_pipe;
	logic [CAL_W-1:0] calib_cnt;
	logic [PH_W-1:0] phase;
	logic [MEM_AW-1:0] idx;
	logic wr_acc;
	logic rd_acc;

	// Wide word index from the narrow-unit address
	assign idx = app_addr[LANE_W +: MEM_AW];

	// Not ready on the last cycle of each period
	assign app_rdy = calib_done && (phase != PH_W'(`RDY_PERIOD - 1));
	assign app_wdf_rdy = app_rdy;

	assign wr_acc = app_en && app_rdy && app_wdf_wren
		&& (app_cmd == ramtest_pkg::CMD_WRITE);
	assign rd_acc = app_en && app_rdy && (app_cmd == ramtest_pkg::CMD_READ);

	assign app_rd_data = rd_pipe[`RD_LATENCY-1];
	assign app_rd_data_valid = vld_pipe[`RD_LATENCY-1];

	always_ff @(posedge okClk) begin
		if (wr_acc)
			mem[idx] <= app_wdf_data;
		rd_pipe[0] <= mem[idx];
		for (int i = 1; i < `RD_LATENCY; i++)
			rd_pipe[i] <= rd_pipe[i-1];
	end

	always_ff @(posedge okClk) begin
		if (rst) begin
			calib_cnt <= '0;
			calib_done <= 1'b0;
			phase <= '0;
			vld_pipe <= '0;
		end else begin
			if (!calib_done) begin
				calib_cnt <= calib_cnt + 1'b1;
				if (calib_cnt == CAL_W'(`CALIB_CYCLES - 1))
					calib_done <= 1'b1;
			end
			phase <= (phase == PH_W'(`RDY_PERIOD - 1)) ? '0 : phase + 1'b1;
			vld_pipe <= {vld_pipe[`RD_LATENCY-2:0], rd_acc};
		end
	end

endmodule

// File: ramtest.sv
//--------------------
// RAM streaming test top
// Pipe-in FIFO, traffic engine, memory model and
// pipe-out FIFO on one clock
//--------------------
module ramtest (
	input  logic                  okClk,
	input  logic                  rst,
	input  logic                  reads_en,
	input  logic                  writes_en,
	input  logic                  pi_write,
	input  ramtest_pkg::narrow_t  pi_data,
	output logic                  pi_ready,
	input  logic                  po_read,
	output ramtest_pkg::narrow_t  po_data,
	output logic                  po_ready,
	output logic                  calib_done
);

	// Engine to FIFOs
	logic ib_re;
	ramtest_pkg::wide_t ib_data;
	ramtest_pkg::wide_count_t ib_count;
	logic ob_we;
	ramtest_pkg::wide_t ob_data;
	ramtest_pkg::wide_count_t ob_count;

	// Engine to memory
	logic app_en;
	logic app_rdy;
	ramtest_pkg::app_cmd_t app_cmd;
	ramtest_pkg::app_addr_t app_addr;
	logic app_wdf_rdy;
	logic app_wdf_wren;
	ramtest_pkg::wide_t app_wdf_data;
	ramtest_pkg::wide_t app_rd_data;
	logic app_rd_data_valid;

	pipe_in_fifo i_pipe_in_fifo (
		.okClk(okClk), .rst(rst), .wr_en(pi_write), .din(pi_data),
		.rd_en(ib_re), .dout(ib_data), .count(ib_count), .empty(),
		.block_space(pi_ready)
	);

	ddr3_test i_ddr3_test (
		.okClk(okClk), .rst(rst), .reads_en(reads_en), .writes_en(writes_en),
		.calib_done(calib_done), .ib_re(ib_re), .ib_data(ib_data), .ib_count(ib_count),
		.ob_we(ob_we), .ob_data(ob_data), .ob_count(ob_count),
		.app_rdy(app_rdy), .app_en(app_en), .app_cmd(app_cmd), .app_addr(app_addr),
		.app_wdf_rdy(app_wdf_rdy), .app_wdf_wren(app_wdf_wren),
		.app_wdf_data(app_wdf_data), .app_rd_data(app_rd_data),
		.app_rd_data_valid(app_rd_data_valid)
	);

	app_mem i_app_mem (
		.okClk(okClk), .rst(rst), .app_en(app_en), .app_cmd(app_cmd),
		.app_addr(app_addr), .app_wdf_wren(app_wdf_wren), .app_wdf_data(app_wdf_data),
		.app_rdy(app_rdy), .app_wdf_rdy(app_wdf_rdy), .app_rd_data(app_rd_data),
		.app_rd_data_valid(app_rd_data_valid), .calib_done(calib_done)
	);

	pipe_out_fifo i_pipe_out_fifo (
		.okClk(okClk), .rst(rst), .wr_en(ob_we), .din(ob_data),
		.rd_en(po_read), .dout(po_data), .count(ob_count), .block_avail(po_ready)
	);

endmodule

// File: tb_ramtest.sv
//--------------------
// RAM streaming testbench
// Directed tests for reset state, round trip, input throttle,
// output back-pressure and memory address wrap
//--------------------
`include "ramtest_macros.svh"

module tb_ramtest;

	localparam int BLOCK = `BLOCK_NARROW;
	localparam int CAP_NARROW = `IN_DEPTH_WIDE * `PACK;
	localparam int MIN_FREE = `BLOCK_NARROW + `HEADROOM;
	localparam int WRAP_BLOCKS = 80 * `PACK / `BLOCK_NARROW;
	// Host words sent over all tests
	localparam int TOTAL_WORDS = 2 * BLOCK + 7 * BLOCK + 12 * BLOCK + WRAP_BLOCKS * BLOCK;
	// About 20 cycles per word covers the slowest test
	localparam int WATCHDOG_CYCLES = 20 * TOTAL_WORDS;

	logic okClk = 1'b0;
	logic rst;
	logic reads_en;
	logic writes_en;
	logic pi_write;
	ramtest_pkg::narrow_t pi_data;
	logic pi_ready;
	logic po_read;
	ramtest_pkg::narrow_t po_data;
	logic po_ready;
	logic calib_done;

	// Expected host words and the memory image they build
	ramtest_pkg::narrow_t exp_q[$];
	ramtest_pkg::wide_t mem_img [0:`MEM_WORDS-1];
	ramtest_pkg::wide_t asm_word;
	int asm_lane;
	int wide_written;
	logic [31:0] lfsr;

	ramtest i_ramtest (
		.okClk(okClk), .rst(rst), .reads_en(reads_en), .writes_en(writes_en),
		.pi_write(pi_write), .pi_data(pi_data), .pi_ready(pi_ready),
		.po_read(po_read), .po_data(po_data), .po_ready(po_ready),
		.calib_done(calib_done)
	);

	always #20 okClk = ~okClk;

	//--------------------
	// Helpers
	//--------------------
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// One LFSR step per data bit
	function ramtest_pkg::narrow_t random_word();
		ramtest_pkg::narrow_t w;
		w = '0;
		for (int b = 0; b < `NARROW_W; b++) begin
			lfsr = lfsr_step(lfsr);
			w = {w[`NARROW_W-2:0], lfsr[0]};
		end
		return w;
	endfunction

	task abort_run(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task check_narrow(input ramtest_pkg::narrow_t actual, input ramtest_pkg::narrow_t expected,
		input string what);
		if (actual !== expected)
			abort_run($sformatf("mismatch at %0t: %s is %h, expected %h",
				$time, what, actual, expected));
	endtask

	task check_flag(input logic actual, input logic expected, input string what);
		if (actual !== expected)
			abort_run($sformatf("mismatch at %0t: %s is %b, expected %b",
				$time, what, actual, expected));
	endtask

	// First word of a group lands in the lowest lane
	task record_word(input ramtest_pkg::narrow_t w);
		exp_q.push_back(w);
		asm_word[asm_lane*`NARROW_W +: `NARROW_W] = w;
		asm_lane++;
		if (asm_lane == `PACK) begin
			mem_img[wide_written % `MEM_WORDS] = asm_word;
			wide_written++;
			asm_lane = 0;
		end
	endtask

	task wait_pi_ready;
		do @(negedge okClk); while (!pi_ready);
	endtask

	task wait_po_ready;
		do @(negedge okClk); while (!po_ready);
	endtask

	task send_block;
		ramtest_pkg::narrow_t w;
		wait_pi_ready();
		for (int i = 0; i < BLOCK; i++) begin
			@(posedge okClk);
			w = random_word();
			pi_write <= 1'b1;
			pi_data <= w;
			record_word(w);
		end
		@(posedge okClk);
		pi_write <= 1'b0;
	endtask

	task drain_block;
		ramtest_pkg::narrow_t expected;
		wait_po_ready();
		for (int i = 0; i < BLOCK; i++) begin
			@(posedge okClk);
			po_read <= 1'b1;
			@(negedge okClk);
			if (exp_q.size() == 0)
				abort_run("pipe-out delivered more words than the host sent");
			expected = exp_q.pop_front();
			check_narrow(po_data, expected, "po_data");
		end
		@(posedge okClk);
		po_read <= 1'b0;
		// po_ready trails the drained count by one cycle
		@(posedge okClk);
	endtask

	//--------------------
	// Tests
	//--------------------
	task test_reset_state;
		@(negedge okClk);
		check_flag(pi_ready, 1'b1, "pi_ready after reset");
		check_flag(po_ready, 1'b0, "po_ready after reset");
		check_flag(calib_done, 1'b0, "calib_done after reset");
		do @(negedge okClk); while (!calib_done);
	endtask

	task test_round_trip;
		@(posedge okClk);
		reads_en <= 1'b1;
		writes_en <= 1'b1;
		repeat (2) send_block();
		repeat (2) drain_block();
	endtask

	task test_input_throttle;
		ramtest_pkg::narrow_t w;
		@(posedge okClk);
		writes_en <= 1'b0;
		for (int n = 1; n <= 7 * BLOCK; n++) begin
			@(posedge okClk);
			w = random_word();
			pi_write <= 1'b1;
			pi_data <= w;
			record_word(w);
			@(posedge okClk);
			pi_write <= 1'b0;
			// Two cycles from pi_write to pi_ready
			@(posedge okClk);
			@(negedge okClk);
			check_flag(pi_ready, (CAP_NARROW - n) >= MIN_FREE, "pi_ready during single writes");
		end
		@(posedge okClk);
		writes_en <= 1'b1;
		wait_pi_ready();
		repeat (7) drain_block();
	endtask

	// Output FIFO fills while po_read is idle
	task test_back_pressure;
		@(posedge okClk);
		reads_en <= 1'b1;
		writes_en <= 1'b1;
		repeat (12) send_block();
		repeat (12) drain_block();
	endtask

	task test_address_wrap;
		int base;
		ramtest_pkg::wide_t w;
		@(posedge okClk);
		reads_en <= 1'b0;
		writes_en <= 1'b1;
		// Read pointer sits where this test starts writing
		base = wide_written % `MEM_WORDS;
		repeat (WRAP_BLOCKS) send_block();
		do @(negedge okClk); while (i_ramtest.ib_count != '0);
		exp_q.delete();
		for (int k = 0; k < WRAP_BLOCKS * BLOCK / `PACK; k++) begin
			w = mem_img[(base + k) % `MEM_WORDS];
			for (int j = 0; j < `PACK; j++)
				exp_q.push_back(w[j*`NARROW_W +: `NARROW_W]);
		end
		@(posedge okClk);
		reads_en <= 1'b1;
		repeat (WRAP_BLOCKS) drain_block();
	endtask

	//--------------------
	// Main sequence
	//--------------------
	initial begin
		rst = 1'b1;
		reads_en = 1'b0;
		writes_en = 1'b0;
		pi_write = 1'b0;
		pi_data = '0;
		po_read = 1'b0;
		asm_word = '0;
		asm_lane = 0;
		wide_written = 0;
		lfsr = 32'h2508_c169;
		repeat (16) @(posedge okClk);
		rst <= 1'b0;
		test_reset_state();
		test_round_trip();
		test_input_throttle();
		test_back_pressure();
		test_address_wrap();
		if (exp_q.size() != 0) begin
			abort_run($sformatf("%0d expected words were never read back", exp_q.size()));
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge okClk);
		abort_run($sformatf("timeout: tests did not finish within %0d cycles",
			WATCHDOG_CYCLES));
	end

endmodule

// File: ramtest.f
+incdir+.
ramtest_pkg.sv
pipe_in_fifo.sv
pipe_out_fifo.sv
ddr3_test.sv
app_mem.sv
ramtest.sv
tb_ramtest.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the RAM streaming testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_ramtest -f ramtest.f \
	-o sim_ramtest > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_ramtest > sim.log 2>&1
grep -q "Result: PASSED" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
